/* Bender.yml */
package:
  name: cpu_core

export_include_dirs:
  - include

sources:
  - hw/cpuTypesPkg.sv
  - hw/opcodesPkg.sv
  - hw/trisreg.sv
  - hw/regBlock.sv
  - hw/alu.sv
  - hw/datapath.sv
  - hw/controller.sv
  - hw/sysMemory.sv
  - hw/cpuCore.sv
  - target: test
    files:
      - test/cpuChecker.sv
      - test/tbCpu.sv

/* hw/alu.sv */
// Combinational ALU
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module alu (
	input  wire opcodesPkg::aluFunctions_t aluOp,
	input  wire cpuTypesPkg::word_t        op1,
	input  wire cpuTypesPkg::word_t        op2,
	input  wire                            carryIn,
	output cpuTypesPkg::word_t             result,
	output cpuTypesPkg::flags_t            flags
);

	cpuTypesPkg::word_t bOperand;
	logic               cIn;
	logic [`WORD_W:0]   sumFull;   // one extra bit for carry out
	logic               carryOut;
	logic               overflow;

	always_comb begin
		// subtract as op1 + ~op2 + 1
		bOperand = (aluOp == opcodesPkg::aluSub) ? ~op2 : op2;
		case (aluOp)
			opcodesPkg::aluAdc: cIn = carryIn;
			opcodesPkg::aluSub: cIn = 1'b1;
			default:            cIn = 1'b0;
		endcase
		sumFull = {1'b0, op1} + {1'b0, bOperand} + {{`WORD_W{1'b0}}, cIn};

		carryOut = 1'b0; // logic ops clear c and v
		overflow = 1'b0;
		case (aluOp)
			opcodesPkg::aluAdd, opcodesPkg::aluAdc, opcodesPkg::aluSub: begin
				result   = sumFull[`WORD_W-1:0];
				carryOut = sumFull[`WORD_W];
				// same sign in, different sign out
				overflow = (op1[`WORD_W-1] == bOperand[`WORD_W-1]) &&
				           (result[`WORD_W-1] != op1[`WORD_W-1]);
			end
			opcodesPkg::aluAnd: result = op1 & op2;
			opcodesPkg::aluOr:  result = op1 | op2;
			opcodesPkg::aluXor: result = op1 ^ op2;
			default:            result = op1;  // pass
		endcase

		flags          = '0;
		flags[`FLAG_C] = carryOut;
		flags[`FLAG_Z] = (result == '0);
		flags[`FLAG_N] = result[`WORD_W-1];
		flags[`FLAG_V] = overflow;
	end

endmodule

`default_nettype wire

/* hw/controller.sv */
// Multicycle control FSM
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module controller (
	input  wire                        Clock,
	input  wire                        rstN,
	input  wire cpuTypesPkg::opcodeByte_t opcode,
	input  wire cpuTypesPkg::flags_t   flags,
	output opcodesPkg::aluFunctions_t  aluOp,
	output opcodesPkg::pcSelect_t      pcSel,
	output opcodesPkg::op1Select_t     op1Sel,
	output opcodesPkg::op2Select_t     op2Sel,
	output opcodesPkg::immSelect_t     immSel,
	output opcodesPkg::wdSelect_t      wdSel,
	output opcodesPkg::rs1Select_t     rs1Sel,
	output opcodesPkg::lrSelect_t      lrSel,
	output logic aluEn, aluWe, lrEn, lrWe, pcEn, pcWe, irWe, regWe, memRe,
	output logic                       cFlag,
	output logic                       addrWe,
	output logic                       memWe,
	output logic                       halted
);

	opcodesPkg::ctrlState_t state, nextState;
	opcodesPkg::instr_t     instr;
	cpuTypesPkg::flags_t    flagReg;
	logic flagWe, isAlu, isMem, isBranch, taken;

	assign instr = opcodesPkg::instr_t'(opcode[`OPC_HI-(`WORD_W-8):`OPC_LO-(`WORD_W-8)]);
	assign isAlu = instr inside {opcodesPkg::ADD, opcodesPkg::ADC, opcodesPkg::SUB,
	    opcodesPkg::AND, opcodesPkg::OR, opcodesPkg::XOR, opcodesPkg::ADDI};
	assign isMem = instr inside {opcodesPkg::LDW, opcodesPkg::STW};
	assign isBranch = instr inside {opcodesPkg::BR, opcodesPkg::BZ, opcodesPkg::BNZ,
	    opcodesPkg::BL};
	assign taken = (instr == opcodesPkg::BZ)  ?  flagReg[`FLAG_Z] :
	               (instr == opcodesPkg::BNZ) ? !flagReg[`FLAG_Z] : 1'b1;
	assign cFlag = flagReg[`FLAG_C];

	// reset parks in decode with IR clear, which is a no-op
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state   <= opcodesPkg::decode;
			flagReg <= '0;
		end else begin
			state <= nextState;
			if (flagWe)
				flagReg <= flags;
		end
	end

	always_comb begin
		{aluEn, aluWe, lrEn, lrWe, pcEn, pcWe, irWe, regWe, memRe} = '0;
		{addrWe, memWe, flagWe, halted} = '0;
		pcSel  = opcodesPkg::pcInc;
		wdSel  = opcodesPkg::wdAlu;
		lrSel  = opcodesPkg::lrPc;
		op1Sel = opcodesPkg::op1Rd1;
		op2Sel = opcodesPkg::op2Rd2;
		immSel = opcodesPkg::immShort;
		rs1Sel = opcodesPkg::rs1Ra;
		nextState = state;

		// operand routing follows the instruction in every state
		case (instr)
			opcodesPkg::ADC: aluOp = opcodesPkg::aluAdc;
			opcodesPkg::SUB: aluOp = opcodesPkg::aluSub;
			opcodesPkg::AND: aluOp = opcodesPkg::aluAnd;
			opcodesPkg::OR:  aluOp = opcodesPkg::aluOr;
			opcodesPkg::XOR: aluOp = opcodesPkg::aluXor;
			default:         aluOp = opcodesPkg::aluAdd;
		endcase
		if (instr == opcodesPkg::ADDI) begin
			rs1Sel = opcodesPkg::rs1Rd;
			op2Sel = opcodesPkg::op2Imm;
			immSel = opcodesPkg::immLong;
		end else if (isMem) begin
			op2Sel = opcodesPkg::op2Imm;     // ra + short offset
		end else if (isBranch) begin
			op1Sel = opcodesPkg::op1Pc;
			op2Sel = opcodesPkg::op2Imm;
			immSel = opcodesPkg::immLong;
		end

		case (state)
			opcodesPkg::fetchAddr: begin
				pcEn      = 1'b1;
				addrWe    = 1'b1;
				nextState = opcodesPkg::fetchRead;
			end
			opcodesPkg::fetchRead: begin
				memRe     = 1'b1;
				irWe      = 1'b1;
				pcWe      = 1'b1;            // pc + 1
				nextState = opcodesPkg::decode;
			end
			opcodesPkg::decode: begin
				if (isAlu || isMem || isBranch || instr == opcodesPkg::RET)
					nextState = opcodesPkg::execute;
				else if (instr == opcodesPkg::HALT)
					nextState = opcodesPkg::halt;
				else
					nextState = opcodesPkg::fetchAddr;
			end
			opcodesPkg::execute: begin
				aluWe     = isAlu || isMem;
				nextState = opcodesPkg::fetchAddr;
				if (isAlu)
					nextState = opcodesPkg::writeBack;
				else if (isMem)
					nextState = opcodesPkg::memAddr;
				else if (isBranch) begin
					pcSel = opcodesPkg::pcAluOut;
					pcWe  = taken;
					lrWe  = (instr == opcodesPkg::BL); // old pc is the return address
				end else begin
					pcSel = opcodesPkg::pcLr;     // RET straight from lr
					pcWe  = 1'b1;
				end
			end
			opcodesPkg::memAddr: begin
				aluEn  = 1'b1;
				addrWe = 1'b1;
				if (instr == opcodesPkg::STW) begin
					rs1Sel = opcodesPkg::rs1Rd;   // store data into ALUOUT
					aluOp  = opcodesPkg::aluPassB;
					aluWe  = 1'b1;
				end
				nextState = opcodesPkg::memAccess;
			end
			opcodesPkg::memAccess: begin
				memRe     = (instr == opcodesPkg::LDW);
				aluEn     = (instr == opcodesPkg::STW);
				memWe     = (instr == opcodesPkg::STW);
				nextState = opcodesPkg::writeBack;
			end
			opcodesPkg::writeBack: begin
				if (instr == opcodesPkg::LDW) begin
					memRe = 1'b1;
					wdSel = opcodesPkg::wdSys;
					regWe = 1'b1;
				end else if (isAlu) begin
					aluEn  = 1'b1;
					regWe  = 1'b1;
					flagWe = 1'b1;  // after the write, so ADC still sees the old carry
				end
				nextState = opcodesPkg::fetchAddr;
			end
			default: halted = 1'b1;       // halt holds forever
		endcase
	end

endmodule

`default_nettype wire

/* hw/cpuCore.sv */
// CPU core top level
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
	input  wire                        Clock,
	input  wire                        rstN,
	input  wire                        loadEn,
	input  wire cpuTypesPkg::memAddr_t loadAddr,
	input  wire cpuTypesPkg::word_t    loadData,
	output logic                       storeStrobe,
	output cpuTypesPkg::memAddr_t      storeAddr,
	output cpuTypesPkg::word_t         storeData,
	output logic                       halted
);

	wire cpuTypesPkg::word_t sysBus;       // shared tristate bus
	cpuTypesPkg::word_t        readData;
	cpuTypesPkg::opcodeByte_t  opcode;
	cpuTypesPkg::flags_t       flags;
	opcodesPkg::aluFunctions_t aluOp;
	opcodesPkg::pcSelect_t     pcSel;
	opcodesPkg::op1Select_t    op1Sel;
	opcodesPkg::op2Select_t    op2Sel;
	opcodesPkg::immSelect_t    immSel;
	opcodesPkg::wdSelect_t     wdSel;
	opcodesPkg::rs1Select_t    rs1Sel;
	opcodesPkg::lrSelect_t     lrSel;
	logic aluEn, aluWe, lrEn, lrWe, pcEn, pcWe, irWe, regWe, memRe;
	logic cFlag, addrWe, memWe;

	datapath datapath_i (
		.Clock, .rstN, .sysBus, .dataIn (readData), .opcode, .flags,
		.aluOp, .pcSel, .op1Sel, .op2Sel, .immSel, .wdSel, .rs1Sel, .lrSel,
		.aluEn, .aluWe, .lrEn, .lrWe, .pcEn, .pcWe, .irWe, .regWe, .memRe, .cFlag
	);

	controller controller_i (
		.Clock, .rstN, .opcode, .flags,
		.aluOp, .pcSel, .op1Sel, .op2Sel, .immSel, .wdSel, .rs1Sel, .lrSel,
		.aluEn, .aluWe, .lrEn, .lrWe, .pcEn, .pcWe, .irWe, .regWe, .memRe,
		.cFlag, .addrWe, .memWe, .halted
	);

	sysMemory sysMemory_i (
		.Clock, .sysBus, .readData, .addrWe, .memWe, .memRe,
		.loadEn, .loadAddr, .loadData
	);

	// copy of the memory address for store monitoring
	always_ff @(posedge Clock) begin
		if (addrWe)
			storeAddr <= sysBus[$bits(cpuTypesPkg::memAddr_t)-1:0];
	end

	assign storeStrobe = memWe;
	assign storeData   = sysBus;   // ALUOUT drives the bus during a store

endmodule

`default_nettype wire

/* hw/cpuTypesPkg.sv */
// CPU data types
`default_nettype none

`include "cpu_consts.svh"

package cpuTypesPkg;

	typedef logic [`WORD_W-1:0] word_t;                  // one bus / register word
	typedef logic [$clog2(`REG_COUNT)-1:0] regAddr_t;    // register number
	typedef logic [7:0] opcodeByte_t;                    // upper byte of IR

	// carry, zero, negative, overflow at the FLAG_* positions
	typedef logic [3:0] flags_t;

	typedef logic [$clog2(`MEM_DEPTH)-1:0] memAddr_t;    // word index into memory

endpackage

`default_nettype wire

/* hw/datapath.sv */
// CPU datapath
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module datapath (
	input  wire                            Clock,
	input  wire                            rstN,
	inout  wire cpuTypesPkg::word_t        sysBus,
	input  wire cpuTypesPkg::word_t        dataIn,
	output cpuTypesPkg::opcodeByte_t       opcode,
	output cpuTypesPkg::flags_t            flags,
	input  wire opcodesPkg::aluFunctions_t aluOp,
	input  wire opcodesPkg::pcSelect_t     pcSel,
	input  wire opcodesPkg::op1Select_t    op1Sel,
	input  wire opcodesPkg::op2Select_t    op2Sel,
	input  wire opcodesPkg::immSelect_t    immSel,
	input  wire opcodesPkg::wdSelect_t     wdSel,
	input  wire opcodesPkg::rs1Select_t    rs1Sel,
	input  wire opcodesPkg::lrSelect_t     lrSel,
	input  wire                            aluEn,
	input  wire                            aluWe,
	input  wire                            lrEn,
	input  wire                            lrWe,
	input  wire                            pcEn,
	input  wire                            pcWe,
	input  wire                            irWe,
	input  wire                            regWe,
	input  wire                            memRe,
	input  wire                            cFlag
);

	cpuTypesPkg::word_t    aluRes, rd1, rd2, wData, extended;
	cpuTypesPkg::word_t    op1, op2, pc, pcIn, pcPlusOne, lr, lrIn, ir;
	cpuTypesPkg::regAddr_t rs1In;

	assign opcode = ir[`WORD_W-1:`WORD_W-8];

	assign extended = (immSel == opcodesPkg::immShort) ?
	                  {{(`WORD_W-5){ir[4]}}, ir[4:0]} :
	                  {{(`WORD_W-8){ir[7]}}, ir[7:0]};

	assign sysBus    = memRe ? dataIn : 'z; // memory read data onto the bus
	assign wData     = (wdSel == opcodesPkg::wdSys) ? sysBus : aluRes;
	assign op1       = (op1Sel == opcodesPkg::op1Rd1) ? rd1 : pc;
	assign op2       = (op2Sel == opcodesPkg::op2Rd2) ? rd2 : extended;
	assign lrIn      = (lrSel == opcodesPkg::lrPc) ? pc : sysBus;
	assign pcPlusOne = pc + 1'b1;

	always_comb begin
		case (rs1Sel)
			opcodesPkg::rs1Rd: rs1In = ir[10:8];
			opcodesPkg::rs1Ra: rs1In = ir[7:5];
			default:           rs1In = 3'd7;   // stack register
		endcase
	end

	always_comb begin
		case (pcSel)
			opcodesPkg::pcLr:     pcIn = lr;
			opcodesPkg::pcAluOut: pcIn = aluRes;
			opcodesPkg::pcSysBus: pcIn = sysBus;
			default:              pcIn = pcPlusOne;
		endcase
	end

	regBlock regBlock_i (
		.Clock (Clock),
		.rstN  (rstN),
		.we    (regWe),
		.rs1   (rs1In),
		.rs2   (ir[4:2]),  // rb
		.rw    (ir[10:8]), // rd
		.wData (wData),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	alu alu_i (
		.aluOp   (aluOp),
		.op1     (op1),
		.op2     (op2),
		.carryIn (cFlag),
		.result  (aluRes),
		.flags   (flags)
	);

	trisreg pcReg (
		.Clock   (Clock),
		.rstN    (rstN),
		.regEn   (pcEn),
		.regWe   (pcWe),
		.dataIn  (pcIn),
		.dataOut (pc),
		.trisOut (sysBus)
	);

	trisreg lrReg (
		.Clock   (Clock),
		.rstN    (rstN),
		.regEn   (lrEn),
		.regWe   (lrWe),
		.dataIn  (lrIn),
		.dataOut (lr),
		.trisOut (sysBus)
	);

	// IR only listens to the bus
	trisreg irReg (
		.Clock   (Clock),
		.rstN    (rstN),
		.regEn   (1'b0),
		.regWe   (irWe),
		.dataIn  (sysBus),
		.dataOut (ir),
		.trisOut (sysBus)
	);

	trisreg aluOutReg (
		.Clock   (Clock),
		.rstN    (rstN),
		.regEn   (aluEn),
		.regWe   (aluWe),
		.dataIn  (aluRes),
		.dataOut (),
		.trisOut (sysBus)
	);

endmodule

`default_nettype wire

/* hw/opcodesPkg.sv */
// Control encodings
`default_nettype none

`include "cpu_consts.svh"

package opcodesPkg;

	typedef enum logic [2:0] {
		aluAdd, aluAdc, aluSub, aluAnd, aluOr, aluXor,
		aluPassB // forwards op1, used to move Rd into ALUOUT for stores
	} aluFunctions_t;

	typedef enum logic [1:0] {pcLr, pcAluOut, pcSysBus, pcInc} pcSelect_t;
	typedef enum logic {op1Rd1, op1Pc} op1Select_t;
	typedef enum logic {op2Rd2, op2Imm} op2Select_t;
	typedef enum logic {immShort, immLong} immSelect_t;   // ir[4:0] or ir[7:0], signed
	typedef enum logic {wdSys, wdAlu} wdSelect_t;
	typedef enum logic [1:0] {rs1Rd, rs1Ra, rs1Seven} rs1Select_t;
	typedef enum logic {lrPc, lrSys} lrSelect_t;          // lrPc takes the current pc

	// instruction word: opcode[15:11] rd[10:8] ra[7:5] rb[4:2]
	// short imm is [4:0], long imm is [7:0]
	// code 0 is not assigned and executes as a no-op
	typedef enum logic [`OPC_HI-`OPC_LO:0] {
		ADD  = 5'b00001, // rd = ra + rb
		ADC  = 5'b00010, // rd = ra + rb + c
		SUB  = 5'b00011, // rd = ra - rb, c set means no borrow
		AND  = 5'b00100,
		OR   = 5'b00101,
		XOR  = 5'b00110,
		ADDI = 5'b00111, // rd = rd + long imm
		LDW  = 5'b01000, // rd = mem[ra + short imm]
		STW  = 5'b01001, // mem[ra + short imm] = rd
		BR   = 5'b10000, // pc = pc + long imm, pc already points past the branch
		BZ   = 5'b10001,
		BNZ  = 5'b10010,
		BL   = 5'b10011, // lr = return address, then branch
		RET  = 5'b10100, // pc = lr
		HALT = 5'b11111
	} instr_t;

	typedef enum logic [2:0] {
		fetchAddr, fetchRead, decode, execute,
		memAddr, memAccess, writeBack, halt
	} ctrlState_t;

endpackage

`default_nettype wire

/* hw/regBlock.sv */
// General register file
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module regBlock (
	input  wire                     Clock,
	input  wire                     rstN,
	input  wire                     we,
	input  wire cpuTypesPkg::regAddr_t rs1,
	input  wire cpuTypesPkg::regAddr_t rs2,
	input  wire cpuTypesPkg::regAddr_t rw,
	input  wire cpuTypesPkg::word_t    wData,
	output cpuTypesPkg::word_t         rd1,
	output cpuTypesPkg::word_t         rd2
);

	cpuTypesPkg::word_t regs [`REG_COUNT];

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[rw] <= wData;
		end
	end

	// reads see the old value during a write
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

endmodule

`default_nettype wire

/* hw/sysMemory.sv */
// System memory
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module sysMemory (
	input  wire                        Clock,
	inout  wire cpuTypesPkg::word_t    sysBus,
	output cpuTypesPkg::word_t         readData,
	input  wire                        addrWe,
	input  wire                        memWe,
	input  wire                        memRe,
	input  wire                        loadEn,
	input  wire cpuTypesPkg::memAddr_t loadAddr,
	input  wire cpuTypesPkg::word_t    loadData
);

	cpuTypesPkg::word_t    mem [`MEM_DEPTH];
	cpuTypesPkg::memAddr_t addrReg;

	always_ff @(posedge Clock) begin
		if (addrWe)
			addrReg <= sysBus[$bits(cpuTypesPkg::memAddr_t)-1:0]; // low bits only
	end

	always_ff @(posedge Clock) begin
		if (loadEn)
			mem[loadAddr] <= loadData;     // test load port wins
		else if (memWe)
			mem[addrReg] <= sysBus;
	end

	// zero when not reading
	assign readData = memRe ? mem[addrReg] : '0;

endmodule

`default_nettype wire

/* hw/trisreg.sv */
// Bus register with tristate drive
`timescale 1ns/1ps
`default_nettype none

module trisreg (
	input  wire                Clock,
	input  wire                rstN,
	input  wire                regEn,   // drive onto the bus
	input  wire                regWe,
	input  wire cpuTypesPkg::word_t dataIn,
	output cpuTypesPkg::word_t dataOut,
	output wire cpuTypesPkg::word_t trisOut
);

	always_ff @(posedge Clock) begin
		if (!rstN)
			dataOut <= '0;
		else if (regWe)
			dataOut <= dataIn;
	end

	assign trisOut = regEn ? dataOut : 'z; // release bus when not selected

endmodule

`default_nettype wire

/* include/cpu_consts.svh */
// CPU core constants
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_W     16  // data and instruction width
`define REG_COUNT  8   // general registers, R7 doubles as stack register
`define MEM_DEPTH  256 // words of system memory

// opcode field in the instruction word
`define OPC_HI     15
`define OPC_LO     11

// bit positions inside flags_t
`define FLAG_C     0
`define FLAG_Z     1
`define FLAG_N     2
`define FLAG_V     3

`endif

/* list.f */
+incdir+include
hw/cpuTypesPkg.sv
hw/opcodesPkg.sv
hw/trisreg.sv
hw/regBlock.sv
hw/alu.sv
hw/datapath.sv
hw/controller.sv
hw/sysMemory.sv
hw/cpuCore.sv
test/cpuChecker.sv
test/tbCpu.sv

/* test/cpuChecker.sv */
// CPU store checker
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuChecker (
	input  wire                        Clock,
	input  wire                        rstN,
	input  wire                        loadEn,
	input  wire cpuTypesPkg::memAddr_t loadAddr,
	input  wire cpuTypesPkg::word_t    loadData,
	input  wire                        storeStrobe,
	input  wire cpuTypesPkg::memAddr_t storeAddr,
	input  wire cpuTypesPkg::word_t    storeData,
	input  wire                        halted,
	output int                         mismatches,
	output int                         storesChecked
);

	cpuTypesPkg::word_t    modelMem [`MEM_DEPTH]; // mirror of DUT memory
	cpuTypesPkg::memAddr_t expAddr [64];
	cpuTypesPkg::word_t    expData [64];
	int   expCount = 0;
	int   storeIdx = 0;
	int   errCount = 0;
	int   compared = 0;
	logic modelHalts = 1'b0;
	logic inReset = 1'b1;
	logic haltSeen = 1'b0;

	assign mismatches    = errCount;
	assign storesChecked = compared;

	// interprets the loaded image, returns the number of expected stores
	function automatic int runModel();
		cpuTypesPkg::word_t    regs [`REG_COUNT];
		cpuTypesPkg::word_t    pc, lr, ir, a, b, imm8;
		cpuTypesPkg::regAddr_t rd;
		cpuTypesPkg::memAddr_t addr;
		logic [`WORD_W:0]      sum;
		logic [`OPC_HI-`OPC_LO:0] op;
		logic carry, zero, aluDone;
		int   count, steps;
		for (int i = 0; i < `REG_COUNT; i++)
			regs[i] = '0;
		pc = '0;
		lr = '0;
		carry = 1'b0;
		zero = 1'b0;
		count = 0;
		steps = 0;
		modelHalts = 1'b0;
		while (!modelHalts && steps < 5000) begin
			ir = modelMem[pc[7:0]];
			pc = pc + 1'b1;               // branches are relative to the next word
			op = ir[`OPC_HI:`OPC_LO];
			rd = ir[10:8];
			a = regs[ir[7:5]];
			b = regs[ir[4:2]];
			imm8 = {{(`WORD_W-8){ir[7]}}, ir[7:0]};
			addr = a[7:0] + {{3{ir[4]}}, ir[4:0]}; // ra + short offset
			steps++;
			aluDone = 1'b1;
			case (op)
				opcodesPkg::ADD:  sum = {1'b0, a} + b;
				opcodesPkg::ADC:  sum = {1'b0, a} + b + carry;
				opcodesPkg::SUB:  sum = {a >= b, a - b}; // carry means no borrow
				opcodesPkg::AND:  sum = {1'b0, a & b};
				opcodesPkg::OR:   sum = {1'b0, a | b};
				opcodesPkg::XOR:  sum = {1'b0, a ^ b};
				opcodesPkg::ADDI: sum = {1'b0, regs[rd]} + imm8;
				default:          aluDone = 1'b0;
			endcase
			if (aluDone) begin
				regs[rd] = sum[`WORD_W-1:0];
				carry = sum[`WORD_W];
				zero = (sum[`WORD_W-1:0] == '0);
			end else begin
				case (op)
					opcodesPkg::LDW: regs[rd] = modelMem[addr];
					opcodesPkg::STW: begin
						modelMem[addr] = regs[rd];
						if (count < 64) begin
							expAddr[count] = addr;
							expData[count] = regs[rd];
							count++;
						end
					end
					opcodesPkg::BR:  pc = pc + imm8;
					opcodesPkg::BZ:  if (zero) pc = pc + imm8;
					opcodesPkg::BNZ: if (!zero) pc = pc + imm8;
					opcodesPkg::BL: begin
						lr = pc;              // return address
						pc = pc + imm8;
					end
					opcodesPkg::RET:  pc = lr;
					opcodesPkg::HALT: modelHalts = 1'b1;
					default: ;                 // unassigned codes do nothing
				endcase
			end
		end
		return count;
	endfunction

	task automatic checkStore();
		if (haltSeen) begin
			$display("store to address %h at %0t came after halt", storeAddr, $time);
			errCount++;
		end else if (storeIdx >= expCount) begin
			$display("unexpected extra store to address %h at %0t", storeAddr, $time);
			errCount++;
		end else begin
			if (storeAddr !== expAddr[storeIdx]) begin
				$display("** Error at %0t: storeAddr is %h, expected %h",
				         $time, storeAddr, expAddr[storeIdx]);
				errCount++;
			end
			if (storeData !== expData[storeIdx]) begin
				$display("** Error at %0t: storeData is %h, expected %h",
				         $time, storeData, expData[storeIdx]);
				errCount++;
			end
			compared++;
		end
		storeIdx++;
	endtask

	always @(posedge Clock) begin
		if (loadEn)
			modelMem[loadAddr] = loadData;   // same image as the DUT gets
		if (!rstN) begin
			inReset = 1'b1;
		end else begin
			if (inReset) begin
				expCount = runModel();       // new program starts now
				storeIdx = 0;
				haltSeen = 1'b0;
				inReset = 1'b0;
				if (!modelHalts) begin
					$display("reference model did not reach HALT");
					errCount++;
				end
			end
			if (storeStrobe)
				checkStore();
			if (halted && !haltSeen) begin
				haltSeen = 1'b1;
				if (storeIdx != expCount) begin
					$display("core halted after %0d stores, %0d expected", storeIdx, expCount);
					errCount++;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* test/tbCpu.sv */
// CPU core testbench
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module tbCpu;

	logic                  Clock;
	logic                  rstN;
	logic                  loadEn;
	cpuTypesPkg::memAddr_t loadAddr;
	cpuTypesPkg::word_t    loadData;
	wire                   storeStrobe;
	wire cpuTypesPkg::memAddr_t storeAddr;
	wire cpuTypesPkg::word_t    storeData;
	wire                   halted;

	int mismatches, storesChecked;
	int timeouts;
	int haltErrors;
	cpuTypesPkg::word_t image [16];   // program words 0..15
	logic [15:0] lfsrState;

	cpuCore cpuCore_i (
		.Clock, .rstN, .loadEn, .loadAddr, .loadData,
		.storeStrobe, .storeAddr, .storeData, .halted
	);

	cpuChecker cpuChecker_i (
		.Clock, .rstN, .loadEn, .loadAddr, .loadData,
		.storeStrobe, .storeAddr, .storeData, .halted,
		.mismatches, .storesChecked
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one LFSR step per bit
	function automatic cpuTypesPkg::word_t randomBits(input int n);
		cpuTypesPkg::word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[`WORD_W-2:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return v;
	endfunction

	function automatic cpuTypesPkg::word_t encodeReg(input opcodesPkg::instr_t op,
		input cpuTypesPkg::regAddr_t rd, input cpuTypesPkg::regAddr_t ra,
		input cpuTypesPkg::regAddr_t rb);
		return {op, rd, ra, rb, 2'b00};
	endfunction

	function automatic cpuTypesPkg::word_t encodeImm(input opcodesPkg::instr_t op,
		input cpuTypesPkg::regAddr_t rd, input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic cpuTypesPkg::word_t encodeMem(input opcodesPkg::instr_t op,
		input cpuTypesPkg::regAddr_t rd, input cpuTypesPkg::regAddr_t ra,
		input logic [4:0] offset);
		return {op, rd, ra, offset};
	endfunction

	task automatic buildImage(input int prog);
		cpuTypesPkg::word_t rndA, rndB, count;
		for (int i = 0; i < 16; i++)
			image[i] = '0;
		rndA = randomBits(16);
		rndB = randomBits(16);
		case (prog)
			1: begin // every ALU function on two random operands
				image[0]  = encodeImm(opcodesPkg::ADDI, 7, 8'h40); // store base
				image[1]  = encodeImm(opcodesPkg::ADDI, 1, rndA[7:0]);
				image[2]  = encodeImm(opcodesPkg::ADDI, 2, rndB[7:0]);
				image[3]  = encodeReg(opcodesPkg::ADD, 3, 1, 2);
				image[4]  = encodeReg(opcodesPkg::SUB, 4, 1, 2);
				image[5]  = encodeReg(opcodesPkg::AND, 5, 1, 2);
				image[6]  = encodeReg(opcodesPkg::OR, 6, 1, 2);
				image[7]  = encodeReg(opcodesPkg::XOR, 1, 1, 2);
				for (int i = 0; i < 5; i++)
					image[8 + i] = encodeMem(opcodesPkg::STW, (i == 4) ? 1 : 3 + i, 7, i);
				image[13] = {opcodesPkg::HALT, 11'd0};
			end
			2: begin // ADD with carry out, then ADC twice
				image[0]  = encodeImm(opcodesPkg::ADDI, 7, 8'h40);
				image[1]  = encodeMem(opcodesPkg::LDW, 1, 0, 5'd12);
				image[2]  = encodeMem(opcodesPkg::LDW, 2, 0, 5'd13);
				image[3]  = encodeReg(opcodesPkg::ADD, 3, 1, 2);
				image[4]  = encodeReg(opcodesPkg::ADC, 4, 1, 2);
				image[5]  = encodeReg(opcodesPkg::ADC, 5, 3, 0);
				image[6]  = encodeMem(opcodesPkg::STW, 3, 7, 5'd5);
				image[7]  = encodeMem(opcodesPkg::STW, 4, 7, 5'd6);
				image[8]  = encodeMem(opcodesPkg::STW, 5, 7, 5'd7);
				image[9]  = {opcodesPkg::HALT, 11'd0};
				image[12] = rndA | 16'h8000;  // both negative so the sum carries
				image[13] = rndB | 16'h8000;
			end
			3: begin // loads, a negative offset and a read back
				image[0]  = encodeImm(opcodesPkg::ADDI, 7, 8'h48);
				image[1]  = encodeMem(opcodesPkg::LDW, 1, 0, 5'd13);
				image[2]  = encodeMem(opcodesPkg::LDW, 2, 0, 5'd14);
				image[3]  = encodeReg(opcodesPkg::ADD, 3, 1, 2);
				image[4]  = encodeMem(opcodesPkg::STW, 3, 7, 5'h1E); // -2
				image[5]  = encodeMem(opcodesPkg::STW, 1, 7, 5'd15);
				image[6]  = encodeMem(opcodesPkg::LDW, 4, 7, 5'h1E);
				image[7]  = encodeReg(opcodesPkg::XOR, 5, 4, 2);
				image[8]  = encodeMem(opcodesPkg::STW, 5, 7, 5'd1);
				image[9]  = {opcodesPkg::HALT, 11'd0};
				image[13] = rndA;
				image[14] = rndB;
			end
			4: begin // countdown with BNZ, BZ not taken, BR over a store
				count = randomBits(2) + 3;
				image[0]  = encodeImm(opcodesPkg::ADDI, 7, 8'h40);
				image[1]  = encodeImm(opcodesPkg::ADDI, 1, count[7:0]);
				image[2]  = encodeMem(opcodesPkg::STW, 1, 7, 5'd8);     // loop head
				image[3]  = encodeImm(opcodesPkg::ADDI, 7, 8'd1);
				image[4]  = encodeImm(opcodesPkg::ADDI, 1, 8'hFF);
				image[5]  = encodeImm(opcodesPkg::BNZ, 0, 8'hFC);      // back to 2
				image[6]  = encodeImm(opcodesPkg::ADDI, 2, 8'd5);
				image[7]  = encodeImm(opcodesPkg::BZ, 0, 8'd1);
				image[8]  = encodeMem(opcodesPkg::STW, 2, 7, 5'd8);
				image[9]  = encodeImm(opcodesPkg::BR, 0, 8'd1);
				image[10] = encodeMem(opcodesPkg::STW, 1, 7, 5'd9);     // skipped
				image[11] = {opcodesPkg::HALT, 11'd0};
			end
			default: begin // two calls into one routine
				image[0]  = encodeImm(opcodesPkg::ADDI, 7, 8'h50);
				image[1]  = encodeImm(opcodesPkg::BL, 0, 8'd5);
				image[2]  = encodeMem(opcodesPkg::STW, 1, 7, 5'd2);
				image[3]  = encodeImm(opcodesPkg::ADDI, 7, 8'd4);
				image[4]  = encodeImm(opcodesPkg::BL, 0, 8'd2);
				image[5]  = encodeMem(opcodesPkg::STW, 1, 7, 5'd3);
				image[6]  = {opcodesPkg::HALT, 11'd0};
				image[7]  = encodeMem(opcodesPkg::LDW, 2, 0, 5'd12); // routine
				image[8]  = encodeReg(opcodesPkg::ADD, 1, 1, 2);
				image[9]  = encodeMem(opcodesPkg::STW, 1, 7, 5'd0);
				image[10] = {opcodesPkg::RET, 11'd0};
				image[12] = rndA;
			end
		endcase
	endtask

	// reset for 16 cycles while the image goes in, then run to HALT
	task automatic runProgram(input int prog);
		int cycles;
		buildImage(prog);
		@(negedge Clock);
		rstN = 1'b0;
		for (int i = 0; i < 16; i++) begin
			loadEn = 1'b1;
			loadAddr = cpuTypesPkg::memAddr_t'(i);
			loadData = image[i];
			@(negedge Clock);
		end
		loadEn = 1'b0;
		rstN = 1'b1;
		if (halted) begin
			$display("halted is high right after reset in program %0d", prog);
			haltErrors++;
		end
		cycles = 0;
		while (!halted && cycles < 20000) begin
			@(negedge Clock);
			cycles++;
		end
		if (!halted) begin
			$display("timeout: program %0d did not halt within 20000 cycles", prog);
			timeouts++;
		end else begin
			repeat (10) begin // watch for late stores
				@(negedge Clock);
				if (!halted) begin
					$display("halted dropped after HALT in program %0d", prog);
					haltErrors++;
				end
			end
		end
	endtask

	initial begin
		rstN = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		timeouts = 0;
		haltErrors = 0;
		lfsrState = 16'd34;
		for (int p = 1; p <= 5; p++)
			runProgram(p);
		if (storesChecked == 0)
			$display("no store was compared");
		$display("stores compared %0d, store errors %0d, timeouts %0d, halt errors %0d",
		         storesChecked, mismatches, timeouts, haltErrors);
		if (mismatches == 0 && timeouts == 0 && haltErrors == 0 && storesChecked > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
